// ==== verif/mem_trace.txt ====
# grp port op addr strb wdata expect (all hex except grp and the port/op letters)
# grp 1 issues the access together with the next line, expect is checked on reads only
0 d w a0000100 f 11223344 00000000
0 d r a0000100 0 00000000 11223344
0 d w a0000104 f 55667788 00000000
0 d w a0000200 f 0badc0de 00000000
0 d w a0000204 f 600dcafe 00000000
0 d w a0000208 f 13579bdf 00000000
0 d w a000020c f 2468ace0 00000000
0 d r 80000204 0 00000000 600dcafe
0 d r 80000204 0 00000000 600dcafe
0 d w 80000208 f deadbeef 00000000
0 d r 80000208 0 00000000 deadbeef
0 d r a0000208 0 00000000 deadbeef
0 d w 80000200 1 000000ee 00000000
0 d r 80000200 0 00000000 0badc0ee
0 d r a0000200 0 00000000 0badc0ee
0 i r 80000100 0 00000000 11223344
0 i r a0000204 0 00000000 600dcafe
0 i r 00000104 0 00000000 55667788
0 d w a0000300 f aabbccdd 00000000
0 d w a0000300 2 00005500 00000000
0 d w a0000302 c 12340000 00000000
0 d r a0000300 0 00000000 123455dd
0 d w 80000500 f cafef00d 00000000
0 d r a0000500 0 00000000 cafef00d
1 d r 80000300 0 00000000 123455dd
0 i r 80000208 0 00000000 deadbeef
1 d r 80000300 0 00000000 123455dd
0 i r a0000300 0 00000000 123455dd
1 d w a0000400 f 01020304 00000000
0 i r 00000200 0 00000000 0badc0ee
1 i r 80000104 0 00000000 55667788
0 d r 80000500 0 00000000 cafef00d
0 i r a0000400 0 00000000 01020304
0 d r 00000104 0 00000000 55667788

// ==== sim.f ====
rtl/dcache_pkg.sv
rtl/mem_map_pkg.sv
rtl/sramx_if.sv
rtl/mmu.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/sram_store.sv
rtl/mem_subsys_top.sv
verif/mem_subsys_assert.sv
verif/tb_mem_subsys.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_mem_subsys -f sim.f
	./obj_dir/Vtb_mem_subsys > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/10ps

module tb_mem_subsys;

    localparam string trace_path = "verif/mem_trace.txt";

    logic        clk;
    logic        arst_n;
    logic        i_req;
    logic [31:0] i_addr;
    logic        i_addr_ok;
    logic        i_data_ok;
    logic [31:0] i_rdata;
    logic        d_req;
    logic        d_wr;
    logic [3:0]  d_wstrb;
    logic [31:0] d_addr;
    logic [31:0] d_wdata;
    logic        d_addr_ok;
    logic        d_data_ok;
    logic [31:0] d_rdata;

    int          errors;
    int          checks;

    int          grp_q   [$];  // 1 means issued in the same cycle as the next entry
    logic [7:0]  port_q  [$];
    logic [7:0]  op_q    [$];
    logic [31:0] addr_q  [$];
    logic [3:0]  strb_q  [$];
    logic [31:0] wdata_q [$];
    logic [31:0] exp_q   [$];

    mem_subsys_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .i_req     (i_req),
        .i_addr    (i_addr),
        .i_addr_ok (i_addr_ok),
        .i_data_ok (i_data_ok),
        .i_rdata   (i_rdata),
        .d_req     (d_req),
        .d_wr      (d_wr),
        .d_wstrb   (d_wstrb),
        .d_addr    (d_addr),
        .d_wdata   (d_wdata),
        .d_addr_ok (d_addr_ok),
        .d_data_ok (d_data_ok),
        .d_rdata   (d_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // ==========================================================
    // access tasks
    // ==========================================================
    task automatic compare_word(input string sig, input int idx, input logic [31:0] got);
        checks++;
        if (got !== exp_q[idx]) begin
            errors++;
            $display("** Error: access %0d %s = %h, expected %h", idx + 1, sig, got, exp_q[idx]);
        end
    endtask

    task automatic data_access(input int idx);
        @(posedge clk);
        d_req   <= 1'b1;
        d_wr    <= (op_q[idx] == "w");
        d_addr  <= addr_q[idx];
        d_wstrb <= strb_q[idx];
        d_wdata <= wdata_q[idx];
        @(negedge clk);
        while (!d_addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        d_req <= 1'b0;                  // accepted on this edge, address stays put
        @(negedge clk);
        while (!d_data_ok) begin
            @(negedge clk);
        end
        if (op_q[idx] == "r") begin
            compare_word("d_rdata", idx, d_rdata);
        end
    endtask

    task automatic fetch_access(input int idx);
        @(posedge clk);
        i_req  <= 1'b1;
        i_addr <= addr_q[idx];
        @(negedge clk);
        while (!i_addr_ok) begin
            @(negedge clk);
        end
        @(posedge clk);
        i_req <= 1'b0;
        @(negedge clk);
        while (!i_data_ok) begin
            @(negedge clk);
        end
        compare_word("i_rdata", idx, i_rdata);
    endtask

    task automatic run_access(input int idx);
        if (port_q[idx] == "i") begin
            fetch_access(idx);
        end else begin
            data_access(idx);
        end
    endtask

    task automatic finish_run();
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic run_watchdog(input int lines);
        repeat (lines * 40 + 100) @(posedge clk);
        errors++;
        $display("timeout, the trace did not finish within %0d cycles", lines * 40 + 100);
        finish_run();
    endtask

    // ==========================================================
    // trace load and replay
    // ==========================================================
    initial begin
        int               fd;
        int               rc;
        int               n;
        int               k;
        int               grp;
        logic [7:0]       port;
        logic [7:0]       op;
        logic [31:0]      addr;
        logic [3:0]       strb;
        logic [31:0]      wdata;
        logic [31:0]      expv;
        logic [8*160-1:0] header;

        errors  = 0;
        checks  = 0;
        arst_n  = 1'b0;
        i_req   = 1'b0;
        i_addr  = '0;
        d_req   = 1'b0;
        d_wr    = 1'b0;
        d_wstrb = 4'b0000;
        d_addr  = '0;
        d_wdata = '0;

        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the trace file %s", trace_path);
            finish_run();
        end else begin
            rc = $fgets(header, fd);  // two lines naming the columns
            rc = $fgets(header, fd);
            rc = $fscanf(fd, " %d %s %s %h %h %h %h", grp, port, op, addr, strb, wdata, expv);
            while (rc == 7) begin
                grp_q.push_back(grp);
                port_q.push_back(port);
                op_q.push_back(op);
                addr_q.push_back(addr);
                strb_q.push_back(strb);
                wdata_q.push_back(wdata);
                exp_q.push_back(expv);
                rc = $fscanf(fd, " %d %s %s %h %h %h %h", grp, port, op, addr, strb, wdata, expv);
            end
            $fclose(fd);
            n = addr_q.size();
            if (n == 0) begin
                errors++;
                $display("the trace file holds no accesses");
            end

            fork
                run_watchdog(n);
            join_none

            repeat (5) @(posedge clk);
            arst_n <= 1'b1;

            k = 0;
            while (k < n) begin
                if ((grp_q[k] == 1) && (k + 1 < n)) begin
                    fork                        // both ports raise req on the same edge
                        run_access(k);
                        run_access(k + 1);
                    join
                    k = k + 2;
                end else begin
                    run_access(k);
                    k = k + 1;
                end
            end
            repeat (2) @(posedge clk);
            finish_run();
        end
    end

endmodule

// ==== verif/mem_subsys_assert.sv ====
`timescale 1ns/10ps

module mem_subsys_assert (
    input logic        clk,
    input logic        arst_n,
    input logic        req,       // request side under the hold rule
    input logic        addr_ok,
    input logic        wr,
    input logic [31:0] addr,
    input logic        excl_a,    // never high in the same cycle as excl_b
    input logic        excl_b,
    input logic        accept,    // acceptance on the channel with one access in flight
    input logic        done
);
    logic pending_q;  // accepted and still waiting for data_ok

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= 1'b0;
        end else if (accept) begin
            pending_q <= 1'b1;
        end else if (done) begin
            pending_q <= 1'b0;
        end
    end

    // ==========================================================
    // handshake rules
    // ==========================================================
    hold_req_chk : assert property (@(posedge clk) disable iff (!arst_n)
        (req && !addr_ok) |=> (req && $stable(addr) && $stable(wr)))
        else $error("request dropped or changed before addr_ok");

    exclusive_chk : assert property (@(posedge clk) disable iff (!arst_n)
        !(excl_a && excl_b))
        else $error("two exclusive signals high in one cycle");

    single_access_chk : assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> (!pending_q || done))
        else $error("new acceptance before the previous data_ok");

endmodule

// the mmu has no clock, so its channels are watched from the top that owns them
bind mem_subsys_top mem_subsys_assert mmu_side_chk (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (cpu_data.req),
    .addr_ok (cpu_data.addr_ok),
    .wr      (cpu_data.wr),
    .addr    (cpu_data.addr),
    .excl_a  (dcache_bus.req),
    .excl_b  (uncached_bus.req),
    .accept  (cpu_data.req && cpu_data.addr_ok),
    .done    (cpu_data.data_ok)
);

// both data side sources come from one data port, so they never compete
bind mem_arbiter mem_subsys_assert arb_side_chk (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (dc.req),
    .addr_ok (dc.addr_ok),
    .wr      (dc.wr),
    .addr    (dc.addr),
    .excl_a  (dc.req),
    .excl_b  (unc.req),
    .accept  (mem.req && mem.addr_ok),
    .done    (mem.data_ok)
);

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        i_req,
    input  logic [31:0] i_addr,
    output logic        i_addr_ok,
    output logic        i_data_ok,
    output logic [31:0] i_rdata,

    input  logic        d_req,
    input  logic        d_wr,
    input  logic [3:0]  d_wstrb,
    input  logic [31:0] d_addr,
    input  logic [31:0] d_wdata,
    output logic        d_addr_ok,
    output logic        d_data_ok,
    output logic [31:0] d_rdata
);
    import mem_map_pkg::*;

    sramx_if cpu_inst ();      // instruction port as the cpu drives it
    sramx_if cpu_data ();      // data port as the cpu drives it
    sramx_if inst_bus ();      // translated fetches toward the arbiter
    sramx_if dcache_bus ();
    sramx_if uncached_bus ();
    sramx_if dcache_mem ();    // refills and write-throughs
    sramx_if mem_bus ();

    // ==========================================================
    // plain ports into channels
    // ==========================================================
    assign cpu_inst.req   = i_req;
    assign cpu_inst.wr    = 1'b0;   // fetches only read
    assign cpu_inst.wstrb = 4'b0000;
    assign cpu_inst.addr  = i_addr;
    assign cpu_inst.wdata = '0;
    assign i_addr_ok      = cpu_inst.addr_ok;
    assign i_data_ok      = cpu_inst.data_ok;
    assign i_rdata        = cpu_inst.rdata;

    assign cpu_data.req   = d_req;
    assign cpu_data.wr    = d_wr;
    assign cpu_data.wstrb = d_wstrb;
    assign cpu_data.addr  = d_addr;
    assign cpu_data.wdata = d_wdata;
    assign d_addr_ok      = cpu_data.addr_ok;
    assign d_data_ok      = cpu_data.data_ok;
    assign d_rdata        = cpu_data.rdata;

    // ==========================================================
    // block instances
    // ==========================================================
    mmu u_mmu (
        .imem         (cpu_inst),
        .dmem         (cpu_data),
        .imem_out     (inst_bus),
        .dcache_out   (dcache_bus),
        .uncached_out (uncached_bus)
    );

    dcache u_dcache (
        .clk    (clk),
        .arst_n (arst_n),
        .cpu    (dcache_bus),
        .mem    (dcache_mem)
    );

    mem_arbiter u_arbiter (
        .clk    (clk),
        .arst_n (arst_n),
        .dc     (dcache_mem),
        .unc    (uncached_bus),
        .ins    (inst_bus),
        .mem    (mem_bus)
    );

    sram_store #(
        .depth (mem_words_c)
    ) u_sram (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (mem_bus)
    );

endmodule

// ==== rtl/sram_store.sv ====
`timescale 1ns/10ps

module sram_store #(
    parameter int depth = mem_map_pkg::mem_words_c
) (
    input  logic   clk,
    input  logic   arst_n,
    sramx_if.slave bus
);
    logic [31:0]              mem_q [depth];
    logic [31:0]              addr_word;
    logic [$clog2(depth)-1:0] word_idx;
    logic                     accept;
    logic                     data_ok_q;
    logic [31:0]              rdata_q;

    assign addr_word = bus.addr;
    assign word_idx  = addr_word[$clog2(depth)+1:2];  // byte offset is not part of the index
    assign accept    = bus.req;                       // never stalls

    assign bus.addr_ok = bus.req;
    assign bus.data_ok = data_ok_q;
    assign bus.rdata   = rdata_q;

    // response comes exactly one cycle after acceptance
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= accept;
        end
    end

    // ==========================================================
    // storage array
    // ==========================================================
    always_ff @(posedge clk) begin
        if (accept && bus.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wstrb[b]) begin
                    mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
        if (accept && !bus.wr) begin
            rdata_q <= mem_q[word_idx];
        end
    end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter (
    input  logic    clk,
    input  logic    arst_n,
    sramx_if.slave  dc,
    sramx_if.slave  unc,
    sramx_if.slave  ins,
    sramx_if.master mem
);
    typedef enum logic [1:0] {GNT_NONE, GNT_DC, GNT_UNC, GNT_INS} grant_t;

    grant_t owner_q;  // master whose access is in flight on mem
    grant_t sel;      // candidate for the next grant
    logic   busy;

    assign busy = (owner_q != GNT_NONE);

    // fixed priority, dcache first and instruction fetch last
    always_comb begin
        if (dc.req) begin
            sel = GNT_DC;
        end else if (unc.req) begin
            sel = GNT_UNC;
        end else if (ins.req) begin
            sel = GNT_INS;
        end else begin
            sel = GNT_NONE;
        end
    end

    // ==========================================================
    // request mux onto the memory channel
    // ==========================================================
    assign mem.req = !busy && (sel != GNT_NONE);

    always_comb begin
        mem.wr    = 1'b0;
        mem.wstrb = '0;
        mem.addr  = '0;
        mem.wdata = '0;
        case (sel)
            GNT_DC: begin
                mem.wr    = dc.wr;
                mem.wstrb = dc.wstrb;
                mem.addr  = dc.addr;
                mem.wdata = dc.wdata;
            end
            GNT_UNC: begin
                mem.wr    = unc.wr;
                mem.wstrb = unc.wstrb;
                mem.addr  = unc.addr;
                mem.wdata = unc.wdata;
            end
            GNT_INS: begin
                mem.wr    = ins.wr;
                mem.wstrb = ins.wstrb;
                mem.addr  = ins.addr;
                mem.wdata = ins.wdata;
            end
            default: ;
        endcase
    end

    // ==========================================================
    // responses go back to the owner only
    // ==========================================================
    assign dc.addr_ok  = mem.req && mem.addr_ok && (sel == GNT_DC);
    assign unc.addr_ok = mem.req && mem.addr_ok && (sel == GNT_UNC);
    assign ins.addr_ok = mem.req && mem.addr_ok && (sel == GNT_INS);

    assign dc.data_ok  = mem.data_ok && (owner_q == GNT_DC);
    assign unc.data_ok = mem.data_ok && (owner_q == GNT_UNC);
    assign ins.data_ok = mem.data_ok && (owner_q == GNT_INS);

    assign dc.rdata  = (owner_q == GNT_DC)  ? mem.rdata : '0;
    assign unc.rdata = (owner_q == GNT_UNC) ? mem.rdata : '0;
    assign ins.rdata = (owner_q == GNT_INS) ? mem.rdata : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner_q <= GNT_NONE;
        end else if (mem.req && mem.addr_ok) begin
            owner_q <= sel;       // grant held until its data_ok
        end else if (mem.data_ok) begin
            owner_q <= GNT_NONE;
        end
    end

endmodule

// ==== rtl/dcache.sv ====
`timescale 1ns/10ps

module dcache (
    input  logic    clk,
    input  logic    arst_n,
    sramx_if.slave  cpu,
    sramx_if.master mem
);
    import mem_map_pkg::*;
    import dcache_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_HIT, S_REFILL, S_WRITE} state_t;

    state_t      state_q;
    addr_t       req_addr_q;   // captured on acceptance
    logic [3:0]  req_wstrb_q;
    logic [31:0] req_wdata_q;
    word_sel_t   fill_cnt_q;   // word of the line being fetched
    logic        mem_wait_q;   // memory request accepted, data_ok still to come
    logic [31:0] rdata_q;

    logic        valid_q [num_lines_c];
    tag_t        tag_q   [num_lines_c];
    logic [31:0] data_q  [num_lines_c][line_words_c];

    index_t      cpu_idx;
    word_sel_t   cpu_word;
    addr_t       fill_addr;
    logic        hit;
    logic        accept;
    logic        fill_last;

    assign cpu_idx   = cpu.addr.cache.index;
    assign cpu_word  = cpu.addr.cache.word;
    assign hit       = valid_q[cpu_idx] && (tag_q[cpu_idx] == cpu.addr.cache.tag);
    assign accept    = cpu.req && (state_q == S_IDLE);  // one access in flight at a time
    assign fill_last = (fill_cnt_q == word_sel_t'(line_words_c - 1));

    always_comb begin
        fill_addr                = req_addr_q;
        fill_addr.cache.word     = fill_cnt_q;
        fill_addr.cache.byte_off = '0;
    end

    // ==========================================================
    // cpu and memory side handshakes
    // ==========================================================
    assign cpu.addr_ok = accept;
    assign cpu.data_ok = (state_q == S_HIT) || ((state_q == S_WRITE) && mem.data_ok);
    assign cpu.rdata   = rdata_q;

    assign mem.req   = ((state_q == S_REFILL) || (state_q == S_WRITE)) && !mem_wait_q;
    assign mem.wr    = (state_q == S_WRITE);
    assign mem.addr  = (state_q == S_WRITE) ? req_addr_q : fill_addr;
    assign mem.wstrb = (state_q == S_WRITE) ? req_wstrb_q : 4'b0000;
    assign mem.wdata = req_wdata_q;

    // ==========================================================
    // control state
    // ==========================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= S_IDLE;
            fill_cnt_q <= '0;
            mem_wait_q <= 1'b0;
            for (int i = 0; i < num_lines_c; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            if (mem.req && mem.addr_ok) begin
                mem_wait_q <= 1'b1;
            end else if (mem.data_ok) begin
                mem_wait_q <= 1'b0;
            end

            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        if (cpu.wr) begin
                            state_q <= S_WRITE;      // hit or miss, the write goes through
                        end else if (hit) begin
                            state_q <= S_HIT;
                        end else begin
                            state_q    <= S_REFILL;
                            fill_cnt_q <= '0;
                        end
                    end
                end
                S_HIT: state_q <= S_IDLE;
                S_REFILL: begin
                    if (mem.data_ok) begin
                        fill_cnt_q <= fill_cnt_q + 1'b1;
                        if (fill_last) begin
                            valid_q[req_addr_q.cache.index] <= 1'b1;
                            state_q                         <= S_HIT;
                        end
                    end
                end
                S_WRITE: begin
                    if (mem.data_ok) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ==========================================================
    // request capture, tag and data arrays
    // ==========================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q  <= cpu.addr;
            req_wstrb_q <= cpu.wstrb;
            req_wdata_q <= cpu.wdata;
        end
        if (accept && !cpu.wr && hit) begin
            rdata_q <= data_q[cpu_idx][cpu_word];
        end
        if (accept && cpu.wr && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (cpu.wstrb[b]) begin
                    data_q[cpu_idx][cpu_word][8*b +: 8] <= cpu.wdata[8*b +: 8];  // merge strobed bytes
                end
            end
        end
        if ((state_q == S_REFILL) && mem.data_ok) begin
            data_q[req_addr_q.cache.index][fill_cnt_q] <= mem.rdata;
            if (fill_cnt_q == req_addr_q.cache.word) begin
                rdata_q <= mem.rdata;                // the word the cpu asked for
            end
            if (fill_last) begin
                tag_q[req_addr_q.cache.index] <= req_addr_q.cache.tag;
            end
        end
    end

endmodule

// ==== rtl/mmu.sv ====
`timescale 1ns/10ps

module mmu (
    sramx_if.slave  imem,
    sramx_if.slave  dmem,
    sramx_if.master imem_out,
    sramx_if.master dcache_out,
    sramx_if.master uncached_out
);
    import mem_map_pkg::*;

    addr_t inst_paddr;
    addr_t data_paddr;
    logic  data_uncached;

    // kseg0 and kseg1 drop the segment bits, all other segments pass as they are
    function automatic addr_t map_addr(input addr_t vaddr);
        addr_t paddr;
        paddr = vaddr;
        if ((vaddr.seg.code == seg_kseg0_c) || (vaddr.seg.code == seg_kseg1_c)) begin
            paddr.seg.code = 3'b000;
        end
        return paddr;
    endfunction

    assign inst_paddr    = map_addr(imem.addr);
    assign data_paddr    = map_addr(dmem.addr);
    assign data_uncached = (dmem.addr.seg.code == seg_kseg1_c);  // only kseg1 skips the cache

    // ==========================================================
    // instruction side goes straight on
    // ==========================================================
    assign imem_out.req   = imem.req;
    assign imem_out.wr    = imem.wr;
    assign imem_out.wstrb = imem.wstrb;
    assign imem_out.addr  = inst_paddr;
    assign imem_out.wdata = imem.wdata;
    assign imem.addr_ok   = imem_out.addr_ok;
    assign imem.data_ok   = imem_out.data_ok;
    assign imem.rdata     = imem_out.rdata;

    // ==========================================================
    // data side is steered by segment
    // ==========================================================
    assign dcache_out.req   = dmem.req && !data_uncached;
    assign dcache_out.wr    = dmem.wr;
    assign dcache_out.wstrb = dmem.wstrb;
    assign dcache_out.addr  = data_paddr;
    assign dcache_out.wdata = dmem.wdata;

    assign uncached_out.req   = dmem.req && data_uncached;
    assign uncached_out.wr    = dmem.wr;
    assign uncached_out.wstrb = dmem.wstrb;
    assign uncached_out.addr  = data_paddr;
    assign uncached_out.wdata = dmem.wdata;

    // the address is stable until data_ok, so the response route is too
    assign dmem.addr_ok = data_uncached ? uncached_out.addr_ok : dcache_out.addr_ok;
    assign dmem.data_ok = data_uncached ? uncached_out.data_ok : dcache_out.data_ok;
    assign dmem.rdata   = data_uncached ? uncached_out.rdata   : dcache_out.rdata;

endmodule

// ==== rtl/sramx_if.sv ====
`timescale 1ns/10ps

interface sramx_if;
    import mem_map_pkg::*;

    logic        req;      // held until addr_ok
    logic        wr;
    logic [3:0]  wstrb;    // byte enables, only meaningful on writes
    addr_t       addr;
    logic [31:0] wdata;

    logic        addr_ok;  // request accepted in this cycle
    logic        data_ok;  // one per accepted request, in order
    logic [31:0] rdata;

    modport master (
        output req, wr, wstrb, addr, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport slave (
        input  req, wr, wstrb, addr, wdata,
        output addr_ok, data_ok, rdata
    );

endinterface

// ==== rtl/mem_map_pkg.sv ====
package mem_map_pkg;

    // ==========================================================
    // fixed-mapped segments
    // ==========================================================
    typedef logic [2:0] seg_t;

    localparam seg_t seg_kseg0_c = 3'b100;  // direct mapped and cached
    localparam seg_t seg_kseg1_c = 3'b101;  // direct mapped and uncached

    localparam int mem_words_c = 1024;      // depth of the on-chip word memory

    // the top three bits pick the segment
    typedef struct packed {
        seg_t        code;
        logic [28:0] offset;
    } seg_view_t;

    // the same word as the data cache splits it
    typedef struct packed {
        dcache_pkg::tag_t      tag;
        dcache_pkg::index_t    index;
        dcache_pkg::word_sel_t word;
        dcache_pkg::byte_off_t byte_off;
    } cache_view_t;

    // ==========================================================
    // one address word with two decodings
    // ==========================================================
    typedef union packed {
        seg_view_t   seg;    // read by the mmu
        cache_view_t cache;  // read by the dcache
    } addr_t;

endpackage

// ==== rtl/dcache_pkg.sv ====
package dcache_pkg;

    // ==========================================================
    // data cache geometry
    // ==========================================================
    localparam int line_words_c = 4;     // words per cache line
    localparam int num_lines_c  = 16;    // direct mapped, one way
    localparam int byte_bits_c  = 2;     // byte offset inside a 32-bit word

    localparam int word_bits_c  = $clog2(line_words_c);
    localparam int index_bits_c = $clog2(num_lines_c);
    localparam int tag_bits_c   = 32 - index_bits_c - word_bits_c - byte_bits_c;

    // ==========================================================
    // address field types
    // ==========================================================
    typedef logic [tag_bits_c-1:0]   tag_t;       // whatever is left above the index
    typedef logic [index_bits_c-1:0] index_t;     // selects the line
    typedef logic [word_bits_c-1:0]  word_sel_t;  // selects the word inside a line
    typedef logic [byte_bits_c-1:0]  byte_off_t;

endpackage
